//--- source/periph_pkg.sv
package periph_pkg;

    typedef logic [10:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  size_n_t;
    typedef logic [3:0]  slot_t;

    // Access size codes, as driven by the core
    localparam size_n_t SIZE_BYTE = 2'b00;
    localparam size_n_t SIZE_HALF = 2'b01;
    localparam size_n_t SIZE_WORD = 2'b10;
    localparam size_n_t SIZE_NONE = 2'b11;

    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        size_n_t write_n;
        size_n_t read_n;
    } periph_req_t;

    typedef struct packed {
        data_t rdata;
        logic  ready;
    } periph_rsp_t;

    // Pin source: simple set picks the byte-interface space
    typedef struct packed {
        logic  simple;
        slot_t slot;
    } func_sel_t;

    localparam int    NUM_SLOTS    = 16;
    localparam int    NUM_PINS     = 8;
    localparam slot_t SLOT_GPIO    = 4'd1;
    localparam slot_t SLOT_SCRATCH = 4'd4;
    localparam slot_t SLOT_EDGE    = 4'd1;

    localparam func_sel_t FUNC_SEL_RESET = '{simple: 1'b0, slot: SLOT_GPIO};

    // Address fields
    function automatic logic is_simple_space(addr_t a);
        return a[10];
    endfunction

    function automatic slot_t user_slot(addr_t a);
        return a[9:6];
    endfunction

    function automatic slot_t simple_slot(addr_t a);
        return a[7:4];
    endfunction

    function automatic logic is_access(size_n_t s);
        return s != SIZE_NONE;
    endfunction

endpackage

//--- source/periph_bus_front.sv
`timescale 1ns/1ps

module periph_bus_front (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::addr_t       i_addr,
    input  periph_pkg::data_t       i_wdata,
    input  periph_pkg::size_n_t     i_data_write_n,
    input  periph_pkg::size_n_t     i_data_read_n,
    input  logic                    i_data_read_complete,
    input  periph_pkg::periph_rsp_t i_rsp,
    output periph_pkg::periph_req_t o_req,
    output periph_pkg::data_t       o_data_out,
    output logic                    o_data_ready
);
    import periph_pkg::*;

    data_t data_q;
    logic  hold_q;
    logic  ready_q;
    logic  read_req;
    logic  capture;

    assign read_req = is_access(i_data_read_n);
    assign capture  = read_req && i_rsp.ready && !hold_q;

    // Hide the pending read from the slots once its data is registered
    assign o_req.addr    = i_addr;
    assign o_req.wdata   = i_wdata;
    assign o_req.write_n = i_data_write_n;
    assign o_req.read_n  = i_data_read_n | {2{ready_q}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.rdata;
        end
    end

    assign o_data_out = data_q;
    // Writes complete in the request cycle
    assign o_data_ready = ready_q || is_access(i_data_write_n);

endmodule

//--- source/periph_addr_decode.sv
`timescale 1ns/1ps

module periph_addr_decode (
    input  periph_pkg::addr_t       i_addr,
    input  periph_pkg::data_t       i_user_rdata [periph_pkg::NUM_SLOTS],
    input  logic [15:0]             i_user_ready,
    input  logic [7:0]              i_simple_rdata [periph_pkg::NUM_SLOTS],
    output logic [15:0]             o_user_sel,
    output logic [15:0]             o_simple_sel,
    output periph_pkg::periph_rsp_t o_rsp
);
    import periph_pkg::*;

    slot_t u_slot;
    slot_t s_slot;

    assign u_slot = user_slot(i_addr);
    assign s_slot = simple_slot(i_addr);

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;

        if (is_simple_space(i_addr)) begin
            // Byte slots are always ready and return 8 bits
            o_simple_sel[s_slot] = 1'b1;
            o_rsp.rdata          = data_t'(i_simple_rdata[s_slot]);
            o_rsp.ready          = 1'b1;
        end else begin
            o_user_sel[u_slot] = 1'b1;
            o_rsp.rdata        = i_user_rdata[u_slot];
            o_rsp.ready        = i_user_ready[u_slot];
        end
    end

endmodule

//--- source/gpio_ctrl.sv
`timescale 1ns/1ps

module gpio_ctrl #(
    parameter int NUM_PINS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_sel,
    input  periph_pkg::periph_req_t i_req,
    input  logic [NUM_PINS-1:0]     i_ui_in,
    input  logic [NUM_PINS-1:0]     i_user_pins [periph_pkg::NUM_SLOTS],
    input  logic [NUM_PINS-1:0]     i_simple_pins [periph_pkg::NUM_SLOTS],
    output periph_pkg::data_t       o_rdata,
    output logic [NUM_PINS-1:0]     o_uo_out
);
    import periph_pkg::*;

    localparam logic [5:0] OFS_OUT = 6'h00;
    localparam logic [5:0] OFS_IN  = 6'h04;

    logic [NUM_PINS-1:0] out_q;
    func_sel_t           func_sel_q [NUM_PINS];
    logic [NUM_PINS-1:0] user_src [NUM_SLOTS];
    logic [5:0]          offset;
    logic [2:0]          fsel_idx;
    logic                fsel_hit;
    logic                wr_en;

    assign offset   = i_req.addr[5:0];
    assign wr_en    = i_sel && is_access(i_req.write_n);
    // Function selects live at 0x20 to 0x3c, one word per pin
    assign fsel_idx = offset[4:2];
    assign fsel_hit = offset[5] && (offset[1:0] == 2'b00) && (fsel_idx < NUM_PINS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
            for (int p = 0; p < NUM_PINS; p++) begin
                func_sel_q[p] <= FUNC_SEL_RESET;
            end
        end else if (wr_en) begin
            if (offset == OFS_OUT) begin
                out_q <= i_req.wdata[NUM_PINS-1:0];
            end
            for (int p = 0; p < NUM_PINS; p++) begin
                if (fsel_hit && fsel_idx == 3'(p)) begin
                    func_sel_q[p] <= func_sel_t'(i_req.wdata[4:0]);
                end
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (offset == OFS_OUT) begin
            o_rdata = data_t'(out_q);
        end else if (offset == OFS_IN) begin
            o_rdata = data_t'(i_ui_in);
        end else if (fsel_hit) begin
            o_rdata = data_t'(func_sel_q[fsel_idx]);
        end
    end

    // The GPIO slot drives its pins from the output register
    always_comb begin
        user_src            = i_user_pins;
        user_src[SLOT_GPIO] = out_q;
        for (int p = 0; p < NUM_PINS; p++) begin
            if (func_sel_q[p].simple) begin
                o_uo_out[p] = i_simple_pins[func_sel_q[p].slot][p];
            end else begin
                o_uo_out[p] = user_src[func_sel_q[p].slot][p];
            end
        end
    end

endmodule

//--- source/scratch_regs.sv
`timescale 1ns/1ps

module scratch_regs #(
    parameter int SCRATCH_WORDS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_sel,
    input  periph_pkg::periph_req_t i_req,
    output periph_pkg::data_t       o_rdata,
    output logic [7:0]              o_uo_out,
    output logic                    o_interrupt
);
    import periph_pkg::*;

    localparam int         IDX_W       = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1;
    localparam logic [5:0] OFS_IRQ_SET = 6'h0c;
    localparam logic [5:0] OFS_IRQ_CLR = 6'h10;

    data_t            words_q [SCRATCH_WORDS];
    logic             irq_q;
    logic [5:0]       offset;
    logic [IDX_W-1:0] word_idx;
    logic             word_hit;
    logic             wr_en;

    assign offset   = i_req.addr[5:0];
    assign word_idx = offset[2 +: IDX_W];
    assign word_hit = (offset[1:0] == 2'b00) && (offset[5:2] < SCRATCH_WORDS);
    assign wr_en    = i_sel && is_access(i_req.write_n);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < SCRATCH_WORDS; w++) begin
                words_q[w] <= '0;
            end
        end else if (wr_en && word_hit) begin
            // Narrow writes touch the low lanes only
            case (i_req.write_n)
                SIZE_BYTE: words_q[word_idx][7:0]  <= i_req.wdata[7:0];
                SIZE_HALF: words_q[word_idx][15:0] <= i_req.wdata[15:0];
                default:   words_q[word_idx]       <= i_req.wdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else if (wr_en && offset == OFS_IRQ_SET) begin
            irq_q <= 1'b1;
        end else if (wr_en && offset == OFS_IRQ_CLR) begin
            irq_q <= 1'b0;
        end
    end

    assign o_rdata     = word_hit ? words_q[word_idx] : '0;
    assign o_uo_out    = words_q[0][7:0];
    assign o_interrupt = irq_q;

endmodule

//--- source/edge_counter.sv
`timescale 1ns/1ps

module edge_counter #(
    parameter int NUM_PINS = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_sel,
    input  periph_pkg::periph_req_t i_req,
    input  logic [NUM_PINS-1:0]     i_ui_in,
    output logic [7:0]              o_rdata,
    output logic [NUM_PINS-1:0]     o_uo_out
);
    import periph_pkg::*;

    localparam int IDX_W = (NUM_PINS > 1) ? $clog2(NUM_PINS) : 1;

    logic [7:0]       count_q;
    logic [IDX_W-1:0] pin_idx_q;
    logic             prev_q;
    logic             pin_now;
    logic             wr_en;
    logic [3:0]       offset;

    assign offset  = i_req.addr[3:0];
    assign wr_en   = i_sel && is_access(i_req.write_n);
    assign pin_now = i_ui_in[pin_idx_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q   <= '0;
            pin_idx_q <= '0;
            prev_q    <= 1'b0;
        end else begin
            prev_q <= pin_now;
            // A write to the count clears it, even on an edge
            if (wr_en && offset == 4'h0) begin
                count_q <= '0;
            end else if (pin_now && !prev_q) begin
                count_q <= count_q + 8'd1;
            end
            if (wr_en && offset == 4'h1) begin
                pin_idx_q <= i_req.wdata[IDX_W-1:0];
            end
        end
    end

    assign o_rdata  = (offset == 4'h0) ? count_q :
                      (offset == 4'h1) ? 8'(pin_idx_q) : 8'h00;
    assign o_uo_out = NUM_PINS'(count_q);

endmodule

//--- source/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int NUM_PINS      = periph_pkg::NUM_PINS,
    parameter int SCRATCH_WORDS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_PINS-1:0] i_ui_in,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::data_t   i_wdata,
    input  periph_pkg::size_n_t i_data_write_n,
    input  periph_pkg::size_n_t i_data_read_n,
    input  logic                i_data_read_complete,
    output logic [NUM_PINS-1:0] o_uo_out,
    output periph_pkg::data_t   o_data_out,
    output logic                o_data_ready,
    output logic [15:2]         o_user_interrupts
);
    import periph_pkg::*;

    periph_req_t         req;
    periph_rsp_t         rsp;
    logic [15:0]         user_sel;
    logic [15:0]         simple_sel;
    logic [15:0]         user_ready;
    logic                scratch_irq;
    wire data_t          user_rdata [NUM_SLOTS];
    wire [7:0]           simple_rdata [NUM_SLOTS];
    wire [NUM_PINS-1:0]  user_pins [NUM_SLOTS];
    wire [NUM_PINS-1:0]  simple_pins [NUM_SLOTS];

    periph_bus_front u_front (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_wdata              (i_wdata),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_rsp                (rsp),
        .o_req                (req),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    periph_addr_decode u_decode (
        .i_addr         (req.addr),
        .i_user_rdata   (user_rdata),
        .i_user_ready   (user_ready),
        .i_simple_rdata (simple_rdata),
        .o_user_sel     (user_sel),
        .o_simple_sel   (simple_sel),
        .o_rsp          (rsp)
    );

    // Every kept slot answers in one cycle, empty ones read zero
    assign user_ready = '1;

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_empty
        if (s != SLOT_GPIO && s != SLOT_SCRATCH) begin : g_user
            assign user_rdata[s] = '0;
            assign user_pins[s]  = '0;
        end
        if (s != SLOT_EDGE) begin : g_simple
            assign simple_rdata[s] = '0;
            assign simple_pins[s]  = '0;
        end
    end

    // gpio_ctrl substitutes its own output register for this slot
    assign user_pins[SLOT_GPIO] = '0;

    gpio_ctrl #(.NUM_PINS(NUM_PINS)) u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_sel         (user_sel[SLOT_GPIO]),
        .i_req         (req),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (user_rdata[SLOT_GPIO]),
        .o_uo_out      (o_uo_out)
    );

    scratch_regs #(.SCRATCH_WORDS(SCRATCH_WORDS)) u_scratch (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_sel       (user_sel[SLOT_SCRATCH]),
        .i_req       (req),
        .o_rdata     (user_rdata[SLOT_SCRATCH]),
        .o_uo_out    (user_pins[SLOT_SCRATCH]),
        .o_interrupt (scratch_irq)
    );

    edge_counter #(.NUM_PINS(NUM_PINS)) u_edge (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sel    (simple_sel[SLOT_EDGE]),
        .i_req    (req),
        .i_ui_in  (i_ui_in),
        .o_rdata  (simple_rdata[SLOT_EDGE]),
        .o_uo_out (simple_pins[SLOT_EDGE])
    );

    // Only the scratch slot raises an interrupt
    always_comb begin
        o_user_interrupts               = '0;
        o_user_interrupts[SLOT_SCRATCH] = scratch_irq;
    end

endmodule

//--- dv/periph_checker.sv
`timescale 1ns/1ps

module periph_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::data_t i_data_out,
    input  logic              i_data_ready,
    input  logic [7:0]        i_uo_out,
    input  logic [15:2]       i_user_interrupts,
    output int                o_errors
);
    import periph_pkg::*;

    int n_checks   = 0;
    int n_mismatch = 0;
    int n_other    = 0;

    assign o_errors = n_mismatch + n_other;

    task automatic compare(input string name, input data_t exp, input data_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_read(input string name, input data_t exp);
        compare(name, exp, i_data_out);
    endtask

    task automatic check_pins(input string name, input data_t exp);
        compare(name, exp, data_t'(i_uo_out));
    endtask

    // Interrupt vector is compared as a 16-bit word, bits 1:0 always zero
    task automatic check_irq(input string name, input data_t exp);
        compare(name, exp, data_t'({i_user_interrupts, 2'b00}));
    endtask

    task automatic check_idle();
        n_checks++;
        if (i_data_ready !== 1'b0 || i_user_interrupts !== '0) begin
            n_other++;
            $display("DUT not idle after reset: ready %b, interrupts 0x%04h",
                     i_data_ready, {i_user_interrupts, 2'b00});
        end
    endtask

    // Only the scratch slot may ever raise its interrupt line
    always @(negedge clk) begin
        if (rst_n && (({i_user_interrupts, 2'b00} & ~16'h0010) !== 16'h0000)) begin
            n_other++;
            $display("Unexpected interrupt raised: 0x%04h", {i_user_interrupts, 2'b00});
        end
    end

    task automatic report();
        $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
                 n_checks, n_mismatch, n_other);
    endtask

endmodule

//--- dv/tb_periph.sv
`timescale 1ns/1ps

module tb_periph;
    import periph_pkg::*;

    localparam int         MAX_ENTRIES = 64;
    localparam logic [1:0] OP_WR       = 2'd0;
    localparam logic [1:0] OP_RD       = 2'd1;
    localparam logic [1:0] OP_PIN      = 2'd2;
    localparam logic [1:0] OP_IRQ      = 2'd3;

    // Full slot n sits at n << 6, byte slot n at 0x400 | n << 4
    localparam addr_t      GPIO_BASE    = 11'h040;
    localparam addr_t      SCRATCH_BASE = 11'h100;
    localparam addr_t      EDGE_BASE    = 11'h410;
    localparam addr_t      EMPTY_USER   = 11'h1c0;
    localparam addr_t      EMPTY_SIMPLE = 11'h430;
    localparam logic [7:0] GPIO_OUT     = 8'hA5;
    localparam int         EDGES        = 3;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    addr_t       addr;
    data_t       wdata;
    size_n_t     write_n;
    size_n_t     read_n;
    logic        read_complete;
    logic [7:0]  uo_out;
    data_t       data_out;
    logic        data_ready;
    logic [15:2] user_irq;
    int          check_errors;

    string       tbl_name  [MAX_ENTRIES];
    logic [1:0]  tbl_op    [MAX_ENTRIES];
    addr_t       tbl_addr  [MAX_ENTRIES];
    size_n_t     tbl_size  [MAX_ENTRIES];
    data_t       tbl_wdata [MAX_ENTRIES];
    logic [7:0]  tbl_ui    [MAX_ENTRIES];
    data_t       tbl_exp   [MAX_ENTRIES];
    int          n_entries   = 0;
    int          seed        = 44;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    periph_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_wdata              (wdata),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_user_interrupts    (user_irq)
    );

    periph_checker u_chk (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_data_out        (data_out),
        .i_data_ready      (data_ready),
        .i_uo_out          (uo_out),
        .i_user_interrupts (user_irq),
        .o_errors          (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: table not finished within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_entry(input string name, input logic [1:0] op, input addr_t a,
                             input size_n_t size, input data_t wd, input logic [7:0] ui,
                             input data_t exp);
        tbl_name[n_entries]  = name;
        tbl_op[n_entries]    = op;
        tbl_addr[n_entries]  = a;
        tbl_size[n_entries]  = size;
        tbl_wdata[n_entries] = wd;
        tbl_ui[n_entries]    = ui;
        tbl_exp[n_entries]   = exp;
        n_entries++;
    endtask

    task automatic build_table();
        data_t      rnd_a;
        data_t      rnd_b;
        data_t      rnd_c;
        data_t      rnd_d;
        data_t      exp_b;
        data_t      exp_c;
        logic [7:0] count_val;
        logic [7:0] pins_clr;
        logic [7:0] pins_fsel;
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        rnd_c = $random(seed);
        // Bit 3 set so the routed scratch bit differs from the GPIO bit
        rnd_d = $random(seed) | 32'h8;
        exp_b = {rnd_a[31:8], rnd_b[7:0]};
        exp_c = {exp_b[31:16], rnd_c[15:0]};
        count_val = 8'(EDGES);
        // Pin 1 follows count bit 1, pin 3 follows scratch word 0 bit 3
        pins_clr  = (GPIO_OUT & ~8'h0A) | {4'b0, rnd_d[3], 3'b000};
        pins_fsel = pins_clr | {6'b0, count_val[1], 1'b0};

        add_entry("gpio out write", OP_WR, GPIO_BASE, SIZE_WORD, 32'(GPIO_OUT), 8'h00, '0);
        add_entry("gpio out read", OP_RD, GPIO_BASE, SIZE_WORD, '0, 8'h00, 32'(GPIO_OUT));
        add_entry("gpio out pins", OP_PIN, GPIO_BASE, SIZE_NONE, '0, 8'h00, 32'(GPIO_OUT));
        add_entry("gpio input read", OP_RD, GPIO_BASE + 11'h04, SIZE_WORD, '0, 8'h3C, 32'h3C);
        add_entry("scratch word write", OP_WR, SCRATCH_BASE + 11'h4, SIZE_WORD, rnd_a, 8'h00, '0);
        add_entry("scratch word read", OP_RD, SCRATCH_BASE + 11'h4, SIZE_WORD, '0, 8'h00, rnd_a);
        add_entry("scratch byte write", OP_WR, SCRATCH_BASE + 11'h4, SIZE_BYTE, rnd_b, 8'h00, '0);
        add_entry("scratch byte read", OP_RD, SCRATCH_BASE + 11'h4, SIZE_WORD, '0, 8'h00, exp_b);
        add_entry("scratch half write", OP_WR, SCRATCH_BASE + 11'h4, SIZE_HALF, rnd_c, 8'h00, '0);
        add_entry("scratch half read", OP_RD, SCRATCH_BASE + 11'h4, SIZE_WORD, '0, 8'h00, exp_c);
        add_entry("scratch word0 write", OP_WR, SCRATCH_BASE, SIZE_WORD, rnd_d, 8'h00, '0);
        add_entry("scratch word0 read", OP_RD, SCRATCH_BASE, SIZE_WORD, '0, 8'h00, rnd_d);
        // Empty slot reads follow a nonzero read so stale data shows up
        add_entry("empty full slot read", OP_RD, EMPTY_USER, SIZE_WORD, '0, 8'h00, '0);
        add_entry("irq idle", OP_IRQ, SCRATCH_BASE, SIZE_NONE, '0, 8'h00, '0);
        add_entry("irq set write", OP_WR, SCRATCH_BASE + 11'h0c, SIZE_WORD, '0, 8'h00, '0);
        add_entry("irq raised", OP_IRQ, SCRATCH_BASE, SIZE_NONE, '0, 8'h00, 32'h10);
        add_entry("irq clear write", OP_WR, SCRATCH_BASE + 11'h10, SIZE_WORD, '0, 8'h00, '0);
        add_entry("irq cleared", OP_IRQ, SCRATCH_BASE, SIZE_NONE, '0, 8'h00, '0);
        add_entry("edge pin select write", OP_WR, EDGE_BASE + 11'h1, SIZE_BYTE, 32'h2, 8'h00, '0);
        add_entry("edge pin select read", OP_RD, EDGE_BASE + 11'h1, SIZE_BYTE, '0, 8'h00, 32'h2);
        add_entry("edge count clear", OP_WR, EDGE_BASE, SIZE_BYTE, '0, 8'h00, '0);
        for (int e = 0; e < EDGES; e++) begin
            add_entry("edge pin high", OP_PIN, EDGE_BASE, SIZE_NONE, '0, 8'h04, 32'(GPIO_OUT));
            add_entry("edge pin low", OP_PIN, EDGE_BASE, SIZE_NONE, '0, 8'h00, 32'(GPIO_OUT));
        end
        add_entry("edge count read", OP_RD, EDGE_BASE, SIZE_BYTE, '0, 8'h00, 32'(count_val));
        add_entry("empty byte slot read", OP_RD, EMPTY_SIMPLE, SIZE_BYTE, '0, 8'h00, '0);
        // Bit 4 picks the byte-interface space where slot 1 is the edge counter
        add_entry("fsel pin1 write", OP_WR, GPIO_BASE + 11'h24, SIZE_WORD, 32'h11, 8'h00, '0);
        add_entry("fsel pin1 read", OP_RD, GPIO_BASE + 11'h24, SIZE_WORD, '0, 8'h00, 32'h11);
        add_entry("fsel pin3 write", OP_WR, GPIO_BASE + 11'h2c, SIZE_WORD, 32'h04, 8'h00, '0);
        add_entry("fsel pin3 read", OP_RD, GPIO_BASE + 11'h2c, SIZE_WORD, '0, 8'h00, 32'h04);
        add_entry("routed pins", OP_PIN, GPIO_BASE, SIZE_NONE, '0, 8'h00, 32'(pins_fsel));
        add_entry("edge count write", OP_WR, EDGE_BASE, SIZE_BYTE, 32'h55, 8'h00, '0);
        add_entry("edge count cleared", OP_RD, EDGE_BASE, SIZE_BYTE, '0, 8'h00, '0);
        add_entry("routed pins cleared", OP_PIN, GPIO_BASE, SIZE_NONE, '0, 8'h00, 32'(pins_clr));
    endtask

    // One entry from the table, driven on falling edges
    task automatic apply_entry(input int i);
        @(negedge clk);
        ui_in = tbl_ui[i];
        case (tbl_op[i])
            OP_WR: begin
                addr    = tbl_addr[i];
                wdata   = tbl_wdata[i];
                write_n = tbl_size[i];
                @(posedge clk);
                while (!data_ready) @(posedge clk);
                @(negedge clk);
                write_n = SIZE_NONE;
            end
            OP_RD: begin
                addr   = tbl_addr[i];
                read_n = tbl_size[i];
                @(negedge clk);
                while (!data_ready) @(negedge clk);
                u_chk.check_read(tbl_name[i], tbl_exp[i]);
                read_n        = SIZE_NONE;
                read_complete = 1'b1;
                @(negedge clk);
                read_complete = 1'b0;
            end
            OP_PIN: begin
                @(negedge clk);
                u_chk.check_pins(tbl_name[i], tbl_exp[i]);
            end
            default: begin
                @(negedge clk);
                u_chk.check_irq(tbl_name[i], tbl_exp[i]);
            end
        endcase
    endtask

    initial begin
        rst_n         = 1'b0;
        ui_in         = 8'h00;
        addr          = '0;
        wdata         = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        build_table();
        cycle_limit = n_entries * 8 + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        u_chk.check_idle();

        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end

        @(negedge clk);
        u_chk.report();
        if (check_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
source/periph_pkg.sv
source/periph_bus_front.sv
source/periph_addr_decode.sv
source/gpio_ctrl.sv
source/scratch_regs.sv
source/edge_counter.sv
source/periph_top.sv
dv/periph_checker.sv
dv/tb_periph.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_periph
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation FAILED, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
